// File: bench/axi_wr_bridge_tb.sv
`timescale 1ns/10ps
`include "axi_wr_defs.svh"

module axi_wr_bridge_tb;
  import axi_wr_pkg::*;

  localparam int TMO = 400;

  typedef struct packed {
    logic [`AXI_ADDR_W-1:0] addr;
    logic [`AXI_STRB_W-1:0] strb;
    logic [`AXI_DATA_W-1:0] data;
  } wr_rec_t;

  logic                   clk;
  logic                   rst_n;

  // upstream AXI ports indexed by port number
  logic [1:0]             awvalid;
  logic [1:0]             awready;
  logic [`AXI_ADDR_W-1:0] awaddr [2];
  logic [  `AXI_ID_W-1:0] awid [2];
  logic [            7:0] awlen [2];
  logic [            2:0] awsize [2];
  burst_t                 awburst [2];
  logic [1:0]             wvalid;
  logic [1:0]             wready;
  logic [`AXI_DATA_W-1:0] wdata [2];
  logic [`AXI_STRB_W-1:0] wstrb [2];
  logic [1:0]             wlast;
  logic [1:0]             bvalid;
  logic [1:0]             bready;
  logic [  `AXI_ID_W-1:0] bid [2];
  resp_t                  bresp [2];
  logic [1:0]             b_wait;

  logic [`AXI_ADDR_W-1:0] m_awaddr;
  logic                   m_awvalid;
  logic                   m_awready;
  logic [`AXI_DATA_W-1:0] m_wdata;
  logic [`AXI_STRB_W-1:0] m_wstrb;
  logic                   m_wvalid;
  logic                   m_wready;
  resp_t                  m_bresp;
  logic                   m_bvalid;
  logic                   m_bready;

  // lite slave model state
  logic [`AXI_ADDR_W-1:0] aw_q [$];
  wr_rec_t                w_q [$];
  resp_t                  b_q [$];
  wr_rec_t                wr_q [$];
  resp_t                  err_tab [bit [`AXI_ADDR_W-1:0]];
  int                     ready_pct;

  // expected writes per port and beat counts per burst
  wr_rec_t                exp0_q [$];
  wr_rec_t                exp1_q [$];
  int                     len0_q [$];
  int                     len1_q [$];

  axi_wr_bridge_top i_dut (
    .clk       (clk),        .rst_n     (rst_n),
    .s0_awvalid(awvalid[0]), .s0_awready(awready[0]), .s0_awaddr (awaddr[0]),
    .s0_awid   (awid[0]),    .s0_awlen  (awlen[0]),   .s0_awsize (awsize[0]),
    .s0_awburst(awburst[0]), .s0_wvalid (wvalid[0]),  .s0_wready (wready[0]),
    .s0_wdata  (wdata[0]),   .s0_wstrb  (wstrb[0]),   .s0_wlast  (wlast[0]),
    .s0_bvalid (bvalid[0]),  .s0_bready (bready[0]),  .s0_bid    (bid[0]),
    .s0_bresp  (bresp[0]),
    .s1_awvalid(awvalid[1]), .s1_awready(awready[1]), .s1_awaddr (awaddr[1]),
    .s1_awid   (awid[1]),    .s1_awlen  (awlen[1]),   .s1_awsize (awsize[1]),
    .s1_awburst(awburst[1]), .s1_wvalid (wvalid[1]),  .s1_wready (wready[1]),
    .s1_wdata  (wdata[1]),   .s1_wstrb  (wstrb[1]),   .s1_wlast  (wlast[1]),
    .s1_bvalid (bvalid[1]),  .s1_bready (bready[1]),  .s1_bid    (bid[1]),
    .s1_bresp  (bresp[1]),
    .m_awaddr  (m_awaddr),   .m_awvalid (m_awvalid),  .m_awready (m_awready),
    .m_wdata   (m_wdata),    .m_wstrb   (m_wstrb),    .m_wvalid  (m_wvalid),
    .m_wready  (m_wready),   .m_bresp   (m_bresp),    .m_bvalid  (m_bvalid),
    .m_bready  (m_bready)
  );

  always #10 clk = ~clk;

  task automatic stop_run(input string line);
    $display("%s", line);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  assert property (@(posedge clk) disable iff (!rst_n)
    m_awvalid && !m_awready |=> m_awvalid && $stable(m_awaddr))
    else stop_run("lite AW valid dropped or its address changed before the handshake");

  assert property (@(posedge clk) disable iff (!rst_n)
    m_wvalid && !m_wready |=> m_wvalid && $stable(m_wdata) && $stable(m_wstrb))
    else stop_run("lite W valid dropped or its payload changed before the handshake");

  for (genvar g = 0; g < 2; g++) begin : g_bchk
    assert property (@(posedge clk) disable iff (!rst_n)
      bvalid[g] && !bready[g] |=> bvalid[g] && $stable(bid[g]) && $stable(bresp[g]))
      else stop_run($sformatf("port %0d B valid dropped or its payload changed", g));
    assert property (@(posedge clk) disable iff (!rst_n) bvalid[g] |-> b_wait[g])
      else stop_run($sformatf("port %0d raised B with no burst waiting for it", g));
  end

  // lite slave model pairs AW and W in arrival order
  always @(posedge clk) begin : slave_accept
    wr_rec_t rec;
    if (m_awvalid && m_awready) begin
      aw_q.push_back(m_awaddr);
    end
    if (m_wvalid && m_wready) begin
      w_q.push_back({`AXI_ADDR_W'(0), m_wstrb, m_wdata});
    end
    if (m_bvalid && m_bready) begin
      void'(b_q.pop_front());
    end
    if (aw_q.size() > 0 && w_q.size() > 0) begin
      rec = w_q.pop_front();
      rec.addr = aw_q.pop_front();
      wr_q.push_back(rec);
      b_q.push_back(err_tab.exists(rec.addr) ? err_tab[rec.addr] : OKAY);
    end
  end

  always @(negedge clk) begin
    m_awready = ($urandom % 100) < ready_pct;
    m_wready  = ($urandom % 100) < ready_pct;
    m_bvalid  = (b_q.size() > 0);
    m_bresp   = (b_q.size() > 0) ? b_q[0] : OKAY;
  end

  task automatic run_burst(input int p, input logic [`AXI_ADDR_W-1:0] addr,
                           input logic [`AXI_ID_W-1:0] id, input logic [7:0] len,
                           input logic [2:0] size, input burst_t burst, input bit rand_b);
    wr_rec_t beats [$];
    wr_rec_t rec;
    resp_t   worst;
    int      i;
    int      n;
    worst = OKAY;
    // WRAP walks like INCR
    for (i = 0; i <= int'(len); i++) begin
      rec.addr = (burst == FIXED) ? addr : addr + (`AXI_ADDR_W'(i) << size);
      rec.data = `AXI_DATA_W'($urandom);
      rec.strb = `AXI_STRB_W'($urandom);
      beats.push_back(rec);
      if (err_tab.exists(rec.addr) && err_tab[rec.addr] > worst) begin
        worst = err_tab[rec.addr];
      end
      if (p == 0) begin
        exp0_q.push_back(rec);
      end else begin
        exp1_q.push_back(rec);
      end
    end
    if (p == 0) begin
      len0_q.push_back(int'(len) + 1);
    end else begin
      len1_q.push_back(int'(len) + 1);
    end
    @(negedge clk);
    awvalid[p] = 1'b1;
    awaddr[p]  = addr;
    awid[p]    = id;
    awlen[p]   = len;
    awsize[p]  = size;
    awburst[p] = burst;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > TMO) begin
        stop_run($sformatf("port %0d AW handshake timed out", p));
      end
    end while (!awready[p]);
    for (i = 0; i <= int'(len); i++) begin
      @(negedge clk);
      awvalid[p] = 1'b0;
      wvalid[p]  = 1'b1;
      wdata[p]   = beats[i].data;
      wstrb[p]   = beats[i].strb;
      wlast[p]   = (i == int'(len));
      n = 0;
      do begin
        @(posedge clk);
        n++;
        if (n > TMO) begin
          stop_run($sformatf("port %0d W beat %0d timed out", p, i));
        end
      end while (!wready[p]);
    end
    n = 0;
    do begin
      @(negedge clk);
      wvalid[p] = 1'b0;
      wlast[p]  = 1'b0;
      b_wait[p] = 1'b1;
      bready[p] = rand_b ? 1'($urandom % 2) : 1'b1;
      @(posedge clk);
      n++;
      if (n > TMO) begin
        stop_run($sformatf("port %0d B response timed out", p));
      end
    end while (!(bvalid[p] && bready[p]));
    assert (bid[p] == id && bresp[p] == worst)
      else stop_run($sformatf("MISMATCH at %0t: port %0d B id %h %s, expected id %h %s",
                              $time, p, bid[p], bresp[p].name(), id, worst.name()));
    @(negedge clk);
    bready[p] = 1'b0;
    b_wait[p] = 1'b0;
  endtask

  task automatic random_burst(input int p);
    logic [            2:0] size;
    logic [`AXI_ADDR_W-1:0] addr;
    size = 3'($urandom % 2);
    addr = {1'(p), 19'($urandom % 4096)} & ~((`AXI_ADDR_W'(1) << size) - 1);
    run_burst(p, addr, 4'($urandom), 8'($urandom % 8), size, burst_t'($urandom % 3), 1'b1);
  endtask

  // address bit 19 tells the port and each burst must arrive as one run
  task automatic check_writes();
    wr_rec_t got;
    wr_rec_t exp;
    int      p;
    int      cur;
    int      run;
    run = 0;
    cur = 0;
    while (wr_q.size() > 0) begin
      got = wr_q.pop_front();
      p = int'(got.addr[`AXI_ADDR_W-1]);
      assert (((p == 0) ? exp0_q.size() : exp1_q.size()) > 0)
        else stop_run($sformatf("unexpected lite write to %h", got.addr));
      if (run == 0) begin
        cur = p;
        run = (p == 0) ? len0_q.pop_front() : len1_q.pop_front();
      end
      assert (p == cur) else stop_run("lite writes of two bursts are interleaved");
      exp = (p == 0) ? exp0_q.pop_front() : exp1_q.pop_front();
      assert (got == exp)
        else stop_run($sformatf("MISMATCH at %0t: lite write %h, expected %h",
                                $time, got, exp));
      run--;
    end
    assert (exp0_q.size() == 0 && exp1_q.size() == 0 && run == 0)
      else stop_run("some lite writes of a burst never reached the slave");
  endtask

  initial begin
    void'($urandom(32'h57501dd7));
    clk       = 1'b0;
    rst_n     = 1'b0;
    awvalid   = '0;
    wvalid    = '0;
    wlast     = '0;
    bready    = '0;
    b_wait    = '0;
    m_awready = 1'b0;
    m_wready  = 1'b0;
    m_bvalid  = 1'b0;
    m_bresp   = OKAY;
    ready_pct = 100;
    for (int p = 0; p < 2; p++) begin
      awaddr[p]  = '0;
      awid[p]    = '0;
      awlen[p]   = '0;
      awsize[p]  = '0;
      awburst[p] = INCR;
      wdata[p]   = '0;
      wstrb[p]   = '0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    assert (!m_awvalid && !m_wvalid && bvalid == 2'b00 && awready == 2'b11)
      else stop_run($sformatf("MISMATCH at %0t: bridge not idle after reset", $time));

    run_burst(0, 20'h00100, 4'h3, 8'd3, 3'd1, INCR, 1'b0);
    check_writes();
    run_burst(1, 20'h80040, 4'h5, 8'd4, 3'd1, FIXED, 1'b0);
    check_writes();
    fork
      run_burst(0, 20'h00400, 4'h6, 8'd5, 3'd1, INCR, 1'b0);
      run_burst(1, 20'h80400, 4'h7, 8'd3, 3'd0, INCR, 1'b0);
    join
    check_writes();

    // one erroring beat in the middle of a burst
    err_tab[20'h00204] = SLVERR;
    run_burst(0, 20'h00200, 4'h9, 8'd3, 3'd1, INCR, 1'b0);
    run_burst(0, 20'h00300, 4'ha, 8'd3, 3'd1, INCR, 1'b0);
    check_writes();

    ready_pct = 60;
    repeat (8) begin
      fork
        random_burst(0);
        random_burst(1);
      join
    end
    check_writes();
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: rtl/axi_axil_adapter_wr.sv
`timescale 1ns/10ps
`include "axi_wr_defs.svh"

module axi_axil_adapter_wr (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   awvalid,
  output logic                   awready,
  input  logic [`AXI_ADDR_W-1:0] awaddr,
  input  logic [  `AXI_ID_W-1:0] awid,
  input  logic [            7:0] awlen,
  input  logic [            2:0] awsize,
  input  axi_wr_pkg::burst_t     awburst,

  input  logic                   wvalid,
  output logic                   wready,
  input  logic [`AXI_DATA_W-1:0] wdata,
  input  logic [`AXI_STRB_W-1:0] wstrb,
  input  logic                   wlast,

  output logic                   bvalid,
  input  logic                   bready,
  output logic [  `AXI_ID_W-1:0] bid,
  output axi_wr_pkg::resp_t      bresp,

  axil_wr_if.adapter             lite
);
  import axi_wr_pkg::*;

  localparam int ADDR_W = `AXI_ADDR_W;

  adapter_state_t         state;

  logic [  `AXI_ID_W-1:0] id_q;
  logic [            7:0] len_q;
  logic [            2:0] size_q;
  burst_t                 burst_q;
  logic [`AXI_ADDR_W-1:0] addr_q;
  resp_t                  resp_q;
  resp_t                  resp_nxt;

  logic [            8:0] issue_cnt;
  logic [            8:0] resp_cnt;
  logic                   aw_done;
  logic                   w_done;

  logic                   aw_hs;
  logic                   aw_fire;
  logic                   w_fire;
  logic                   b_fire;
  logic                   beat_done;
  logic                   last_beat;
  logic                   last_resp;

  assign awready   = (state == IDLE);
  assign aw_hs     = awvalid && awready;

  assign lite.awaddr  = addr_q;
  assign lite.wdata   = wdata;
  assign lite.wstrb   = wstrb;
  assign lite.awvalid = (state == BURST) && wvalid && !aw_done;
  assign lite.wvalid  = (state == BURST) && wvalid && !w_done;
  assign lite.lock    = (state != IDLE);

  assign aw_fire   = lite.awvalid && lite.awready;
  assign w_fire    = lite.wvalid && lite.wready;
  assign beat_done = (state == BURST) && (aw_done || aw_fire) && (w_done || w_fire);
  assign wready    = beat_done;

  assign last_beat = (issue_cnt == {1'b0, len_q});
  assign last_resp = (state == RESP) && (resp_cnt == {1'b0, len_q});

  // the final lite response is passed straight through to the upstream B channel
  always_comb begin
    lite.bready = 1'b0;
    if (state == BURST) begin
      lite.bready = (resp_cnt != issue_cnt);
    end else if (state == RESP) begin
      lite.bready = last_resp ? bready : 1'b1;
    end
  end

  assign b_fire = lite.bvalid && lite.bready;
  assign bvalid = last_resp && lite.bvalid;
  assign bid    = id_q;
  assign bresp  = (lite.bresp > resp_q) ? lite.bresp : resp_q;

  always_comb begin
    resp_nxt = resp_q;
    if (b_fire && (lite.bresp > resp_q)) begin
      resp_nxt = lite.bresp;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= IDLE;
      issue_cnt <= '0;
      resp_cnt  <= '0;
      aw_done   <= 1'b0;
      w_done    <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (aw_hs) begin
            state     <= BURST;
            issue_cnt <= '0;
            resp_cnt  <= '0;
          end
        end
        BURST: begin
          if (beat_done && last_beat) begin
            state <= RESP;
          end
        end
        RESP: begin
          if (b_fire && last_resp) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase

      if (beat_done) begin
        issue_cnt <= issue_cnt + 9'd1;
        aw_done   <= 1'b0;
        w_done    <= 1'b0;
      end else begin
        if (aw_fire) begin
          aw_done <= 1'b1;
        end
        if (w_fire) begin
          w_done <= 1'b1;
        end
      end

      if (b_fire) begin
        resp_cnt <= resp_cnt + 9'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      id_q    <= awid;
      len_q   <= awlen;
      size_q  <= awsize;
      burst_q <= awburst;
      addr_q  <= awaddr;
      resp_q  <= OKAY;
    end else begin
      // WRAP walks like INCR
      if (beat_done && (burst_q != FIXED)) begin
        addr_q <= addr_q + (ADDR_W'(1) << size_q);
      end
      resp_q <= resp_nxt;
    end
  end

endmodule

// File: rtl/axi_wr_bridge_top.sv
`timescale 1ns/10ps
`include "axi_wr_defs.svh"

module axi_wr_bridge_top (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   s0_awvalid,
  output logic                   s0_awready,
  input  logic [`AXI_ADDR_W-1:0] s0_awaddr,
  input  logic [  `AXI_ID_W-1:0] s0_awid,
  input  logic [            7:0] s0_awlen,
  input  logic [            2:0] s0_awsize,
  input  axi_wr_pkg::burst_t     s0_awburst,
  input  logic                   s0_wvalid,
  output logic                   s0_wready,
  input  logic [`AXI_DATA_W-1:0] s0_wdata,
  input  logic [`AXI_STRB_W-1:0] s0_wstrb,
  input  logic                   s0_wlast,
  output logic                   s0_bvalid,
  input  logic                   s0_bready,
  output logic [  `AXI_ID_W-1:0] s0_bid,
  output axi_wr_pkg::resp_t      s0_bresp,

  input  logic                   s1_awvalid,
  output logic                   s1_awready,
  input  logic [`AXI_ADDR_W-1:0] s1_awaddr,
  input  logic [  `AXI_ID_W-1:0] s1_awid,
  input  logic [            7:0] s1_awlen,
  input  logic [            2:0] s1_awsize,
  input  axi_wr_pkg::burst_t     s1_awburst,
  input  logic                   s1_wvalid,
  output logic                   s1_wready,
  input  logic [`AXI_DATA_W-1:0] s1_wdata,
  input  logic [`AXI_STRB_W-1:0] s1_wstrb,
  input  logic                   s1_wlast,
  output logic                   s1_bvalid,
  input  logic                   s1_bready,
  output logic [  `AXI_ID_W-1:0] s1_bid,
  output axi_wr_pkg::resp_t      s1_bresp,

  output logic [`AXI_ADDR_W-1:0] m_awaddr,
  output logic                   m_awvalid,
  input  logic                   m_awready,
  output logic [`AXI_DATA_W-1:0] m_wdata,
  output logic [`AXI_STRB_W-1:0] m_wstrb,
  output logic                   m_wvalid,
  input  logic                   m_wready,
  input  axi_wr_pkg::resp_t      m_bresp,
  input  logic                   m_bvalid,
  output logic                   m_bready
);

  axil_wr_if i_lite [`AXI_NUM_PORTS] ();

  axi_axil_adapter_wr i_adapter0 (
    .clk    (clk),        .rst_n  (rst_n),
    .awvalid(s0_awvalid), .awready(s0_awready), .awaddr (s0_awaddr),
    .awid   (s0_awid),    .awlen  (s0_awlen),   .awsize (s0_awsize),
    .awburst(s0_awburst),
    .wvalid (s0_wvalid),  .wready (s0_wready),  .wdata  (s0_wdata),
    .wstrb  (s0_wstrb),   .wlast  (s0_wlast),
    .bvalid (s0_bvalid),  .bready (s0_bready),  .bid    (s0_bid),
    .bresp  (s0_bresp),
    .lite   (i_lite[0])
  );

  axi_axil_adapter_wr i_adapter1 (
    .clk    (clk),        .rst_n  (rst_n),
    .awvalid(s1_awvalid), .awready(s1_awready), .awaddr (s1_awaddr),
    .awid   (s1_awid),    .awlen  (s1_awlen),   .awsize (s1_awsize),
    .awburst(s1_awburst),
    .wvalid (s1_wvalid),  .wready (s1_wready),  .wdata  (s1_wdata),
    .wstrb  (s1_wstrb),   .wlast  (s1_wlast),
    .bvalid (s1_bvalid),  .bready (s1_bready),  .bid    (s1_bid),
    .bresp  (s1_bresp),
    .lite   (i_lite[1])
  );

  axil_wr_arbiter i_arbiter (
    .clk      (clk),       .rst_n    (rst_n),
    .m_awaddr (m_awaddr),  .m_awvalid(m_awvalid), .m_awready(m_awready),
    .m_wdata  (m_wdata),   .m_wstrb  (m_wstrb),
    .m_wvalid (m_wvalid),  .m_wready (m_wready),
    .m_bresp  (m_bresp),   .m_bvalid (m_bvalid),  .m_bready (m_bready),
    .port     (i_lite)
  );

endmodule

// File: rtl/axi_wr_defs.svh
`ifndef AXI_WR_DEFS_SVH
`define AXI_WR_DEFS_SVH

// bus widths shared by every block
`define AXI_ADDR_W 20
`define AXI_DATA_W 16
`define AXI_STRB_W (`AXI_DATA_W / 8)
`define AXI_ID_W 4

// upstream AXI write ports sharing the lite bus
`define AXI_NUM_PORTS 2

`endif

// File: rtl/axi_wr_pkg.sv
package axi_wr_pkg;

  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_t;

  // numeric order doubles as severity, so the largest code is the worst
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_t;

  typedef enum logic [1:0] {
    IDLE,
    BURST,
    RESP
  } adapter_state_t;

endpackage

// File: rtl/axil_wr_arbiter.sv
`timescale 1ns/10ps
`include "axi_wr_defs.svh"

module axil_wr_arbiter (
  input  logic                   clk,
  input  logic                   rst_n,

  output logic [`AXI_ADDR_W-1:0] m_awaddr,
  output logic                   m_awvalid,
  input  logic                   m_awready,
  output logic [`AXI_DATA_W-1:0] m_wdata,
  output logic [`AXI_STRB_W-1:0] m_wstrb,
  output logic                   m_wvalid,
  input  logic                   m_wready,
  input  axi_wr_pkg::resp_t      m_bresp,
  input  logic                   m_bvalid,
  output logic                   m_bready,

  axil_wr_if.arbiter             port [`AXI_NUM_PORTS]
);

  localparam int NUM   = `AXI_NUM_PORTS;
  localparam int IDX_W = $clog2(NUM);

  logic [            NUM-1:0] lock;
  logic [            NUM-1:0] awvalid;
  logic [            NUM-1:0] wvalid;
  logic [            NUM-1:0] bready;
  logic [`AXI_ADDR_W-1:0]     awaddr [NUM];
  logic [`AXI_DATA_W-1:0]     wdata  [NUM];
  logic [`AXI_STRB_W-1:0]     wstrb  [NUM];

  logic                       grant_vld;
  logic [          IDX_W-1:0] owner;
  logic [          IDX_W-1:0] rr_ptr;
  logic                       next_vld;
  logic [          IDX_W-1:0] next_idx;

  // per-port requests gathered into plain vectors
  for (genvar i = 0; i < NUM; i++) begin : g_port
    assign lock[i]    = port[i].lock;
    assign awvalid[i] = port[i].awvalid;
    assign wvalid[i]  = port[i].wvalid;
    assign bready[i]  = port[i].bready;
    assign awaddr[i]  = port[i].awaddr;
    assign wdata[i]   = port[i].wdata;
    assign wstrb[i]   = port[i].wstrb;

    assign port[i].awready = grant_vld && (owner == IDX_W'(i)) && m_awready;
    assign port[i].wready  = grant_vld && (owner == IDX_W'(i)) && m_wready;
    assign port[i].bvalid  = grant_vld && (owner == IDX_W'(i)) && m_bvalid;
    assign port[i].bresp   = m_bresp;
  end

  // nearest locked port at or after the round-robin pointer
  always_comb begin
    int cand;
    next_vld = 1'b0;
    next_idx = rr_ptr;
    for (int k = NUM - 1; k >= 0; k--) begin
      cand = (int'(rr_ptr) + k) % NUM;
      if (lock[cand]) begin
        next_vld = 1'b1;
        next_idx = IDX_W'(cand);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      grant_vld <= 1'b0;
      owner     <= '0;
      rr_ptr    <= '0;
    end else if (!grant_vld || !lock[owner]) begin
      grant_vld <= next_vld;
      if (next_vld) begin
        owner  <= next_idx;
        rr_ptr <= IDX_W'((int'(next_idx) + 1) % NUM);
      end
    end
  end

  assign m_awvalid = grant_vld && awvalid[owner];
  assign m_wvalid  = grant_vld && wvalid[owner];
  assign m_bready  = grant_vld && bready[owner];
  assign m_awaddr  = awaddr[owner];
  assign m_wdata   = wdata[owner];
  assign m_wstrb   = wstrb[owner];

endmodule

// File: rtl/axil_wr_if.sv
`timescale 1ns/10ps
`include "axi_wr_defs.svh"

interface axil_wr_if;
  import axi_wr_pkg::*;

  logic [`AXI_ADDR_W-1:0] awaddr;
  logic                   awvalid;
  logic                   awready;
  logic [`AXI_DATA_W-1:0] wdata;
  logic [`AXI_STRB_W-1:0] wstrb;
  logic                   wvalid;
  logic                   wready;
  resp_t                  bresp;
  logic                   bvalid;
  logic                   bready;
  // held by the adapter for the whole burst
  logic                   lock;

  modport adapter (
    output awaddr, awvalid, wdata, wstrb, wvalid, bready, lock,
    input  awready, wready, bresp, bvalid
  );

  modport arbiter (
    input  awaddr, awvalid, wdata, wstrb, wvalid, bready, lock,
    output awready, wready, bresp, bvalid
  );

endinterface

// File: src.f
+incdir+rtl
rtl/axi_wr_pkg.sv
rtl/axil_wr_if.sv
rtl/axi_axil_adapter_wr.sv
rtl/axil_wr_arbiter.sv
rtl/axi_wr_bridge_top.sv
bench/axi_wr_bridge_tb.sv
